//--- bram_pkg.sv
// geometry defaults and helpers shared by the banked memory and its testbench
package bram_pkg;

  // wide port data word width in bits
  localparam int IN_WIDTH_DEF = 32;

  // bank datum width in whole bytes
  localparam int OUT_WIDTH_DEF = 16;

  // number of narrow banks as a power of two
  localparam int BANKS_DEF = 4;

  // rows per bank as a power of two
  localparam int OUT_DEPTH_DEF = 256;

  // number of data items (lanes) packed lsb to msb in one wide word
  // the lane count is a power of two no larger than the bank count
  // so all lanes of one wide word land in different banks
  function automatic int lane_count(
    input int in_width,   // wide word width
    input int out_width   // bank datum width
  );
    int lanes;
    lanes = in_width / out_width;  // exact for power of two widths
    return lanes;
  endfunction

  // internal data address of lane j at wide address a is {a, j}
  // low bank bits of that address pick the bank and the rest pick the row
  // with the defaults the wide address is 9 bits and the internal one 10 bits
  // bank = itrl[1:0] and row = itrl[9:2]
  // even wide addresses use banks 0 and 1 while odd ones use banks 2 and 3

endpackage

//--- bram_bank_if.sv
`timescale 1ns/1ns

// one bank's single port, driven by the translator and served by a bank RAM
interface bram_bank_if #(
  parameter int OUT_WIDTH = bram_pkg::OUT_WIDTH_DEF,  // datum width
  parameter int OUT_DEPTH = bram_pkg::OUT_DEPTH_DEF   // rows in the bank
);

  localparam int WE_W   = OUT_WIDTH / 8;        // one write enable per byte
  localparam int ADDR_W = $clog2(OUT_DEPTH);    // row address width

  logic              en;      // access this cycle
  logic [WE_W-1:0]   we;      // all zero means read
  logic [ADDR_W-1:0] addr;    // row inside the bank
  logic [OUT_WIDTH-1:0] wrdata;  // write datum
  logic [OUT_WIDTH-1:0] rddata;  // registered read datum, one cycle later

  // translator side
  modport ctrl (
    output en, we, addr, wrdata,
    input  rddata
  );

  // memory side, mirror of ctrl
  modport mem (
    input  en, we, addr, wrdata,
    output rddata
  );

endinterface

//--- bram_bank.sv
`timescale 1ns/1ns

// single-port synchronous RAM bank, byte writable, read-first
module bram_bank #(
  parameter int OUT_WIDTH = bram_pkg::OUT_WIDTH_DEF,  // datum width, whole bytes
  parameter int OUT_DEPTH = bram_pkg::OUT_DEPTH_DEF   // rows
) (
  input  logic      clk_i,
  input  logic      rst_n_i,
  bram_bank_if.mem  port
);

  localparam int OUT_WE = OUT_WIDTH / 8;  // byte lanes in one datum

  logic [OUT_WIDTH-1:0] ram [OUT_DEPTH];  // storage array
  logic [OUT_WIDTH-1:0] rddata_q;         // output register

  // byte-masked write on the sampling edge
  always_ff @(posedge clk_i) begin
    if (port.en) begin
      for (int b = 0; b < OUT_WE; b++) begin
        if (port.we[b]) begin
          ram[port.addr][b*8 +: 8] <= port.wrdata[b*8 +: 8];
        end
      end
    end
  end

  // read register samples the old row, same edge as the write
  // so a mixed access returns the content before the write
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rddata_q <= '0;
    end else if (port.en) begin
      rddata_q <= ram[port.addr];  // holds while en is low
    end
  end

  assign port.rddata = rddata_q;

  // a write-only access also loads rddata_q, the translator
  // only looks at it after an access that targeted this bank
  //
  // with the defaults this is 256 x 16, two byte enables
  // maps to one block RAM in read-first mode

endmodule

//--- bram_intrf_translator.sv
`timescale 1ns/1ns

// splits one wide byte-writable port into BANKS narrow bank ports
// forward path is pure logic, return path uses a registered lane-to-bank map
module bram_intrf_translator #(
  parameter int IN_WIDTH  = bram_pkg::IN_WIDTH_DEF,   // wide word width
  parameter int OUT_WIDTH = bram_pkg::OUT_WIDTH_DEF,  // bank datum width
  parameter int BANKS     = bram_pkg::BANKS_DEF,      // number of banks
  parameter int OUT_DEPTH = bram_pkg::OUT_DEPTH_DEF,  // rows per bank
  localparam int LANES    = bram_pkg::lane_count(IN_WIDTH, OUT_WIDTH),
  localparam int IN_ADDR  = $clog2(BANKS * OUT_DEPTH / LANES)  // wide word address width
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  en_i,      // wide port access
  input  logic [IN_WIDTH/8-1:0] we_i,      // byte enables over the wide word
  input  logic [IN_ADDR-1:0]    addr_i,    // wide word address
  input  logic [IN_WIDTH-1:0]   wrdata_i,  // lanes packed lsb to msb
  output logic [IN_WIDTH-1:0]   rddata_o,  // valid one cycle after en_i
  bram_bank_if.ctrl             banks [BANKS]
);

  localparam int OUT_WE    = OUT_WIDTH / 8;             // byte enables per lane
  localparam int OUT_ADDR  = $clog2(OUT_DEPTH);         // row bits
  localparam int INJ_BITS  = $clog2(LANES);             // lane index appended below addr_i
  localparam int BANK_BITS = $clog2(BANKS);             // bank select bits
  localparam int BSEL_W    = (BANKS > 1) ? BANK_BITS : 1;  // keeps a single bank legal
  localparam int ITRL_ADDR = IN_ADDR + INJ_BITS;        // internal data address width

  logic [ITRL_ADDR-1:0] addr_itrl  [LANES];  // internal data address per lane
  logic [BSEL_W-1:0]    bank_sel   [LANES];  // target bank per lane
  logic [BSEL_W-1:0]    bank_sel_q [LANES];  // target bank of the last enabled access
  logic [BANKS-1:0]     en_onehot  [LANES];  // gated one-hot bank hit per lane
  logic [BANKS-1:0]     en_banks;            // merged bank enables
  logic [OUT_WIDTH-1:0] rd_banks   [BANKS];  // bank read data, flattened for muxing

  function automatic logic [BANKS-1:0] bin_to_onehot(input logic [BSEL_W-1:0] bin);
    logic [BANKS-1:0] oh;
    oh      = '0;
    oh[bin] = 1'b1;
    return oh;
  endfunction

  // lane j of word A lives at internal address {A, j}
  always_comb begin
    for (int j = 0; j < LANES; j++) begin
      addr_itrl[j] = (ITRL_ADDR'(addr_i) << INJ_BITS) | ITRL_ADDR'(j);
      bank_sel[j]  = BSEL_W'(addr_itrl[j] % BANKS);  // low bank bits
      en_onehot[j] = en_i ? bin_to_onehot(bank_sel[j]) : '0;
    end
  end

  // lanes never collide since LANES <= BANKS, so an OR is enough
  always_comb begin
    en_banks = '0;
    for (int j = 0; j < LANES; j++) begin
      en_banks = en_banks | en_onehot[j];
    end
  end

  // bank i is only ever hit by lane i mod LANES
  for (genvar i = 0; i < BANKS; i++) begin : g_bank
    localparam int LANE = i % LANES;

    assign banks[i].en     = en_banks[i];
    assign banks[i].we     = we_i[LANE*OUT_WE +: OUT_WE];
    assign banks[i].addr   = OUT_ADDR'(addr_itrl[LANE] >> BANK_BITS);  // row bits
    assign banks[i].wrdata = wrdata_i[LANE*OUT_WIDTH +: OUT_WIDTH];
    assign rd_banks[i]     = banks[i].rddata;
  end

  // remember where each lane went, banks answer one cycle later
  // held while en_i is low so rddata_o holds as well
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int j = 0; j < LANES; j++) begin
        bank_sel_q[j] <= '0;
      end
    end else if (en_i) begin
      for (int j = 0; j < LANES; j++) begin
        bank_sel_q[j] <= bank_sel[j];
      end
    end
  end

  // reassemble the wide word from the banks of the previous access
  for (genvar j = 0; j < LANES; j++) begin : g_lane
    assign rddata_o[j*OUT_WIDTH +: OUT_WIDTH] = rd_banks[bank_sel_q[j]];
  end

  // example with defaults, addr_i = 5
  //   lane 0 -> itrl 10 -> bank 2 row 2
  //   lane 1 -> itrl 11 -> bank 3 row 2
  // banks 0 and 1 stay idle and keep their read registers
  //
  // a mixed access reads first in every bank it touches,
  // so unwritten bytes come back with their old value too
  //
  // back to back accesses work because the map register and the
  // bank read registers advance on the same edge

endmodule

//--- banked_bram_top.sv
`timescale 1ns/1ns

// banked on-chip memory behind one wide byte-writable port
// wide word lanes are spread over BANKS narrow bank RAMs
module banked_bram_top #(
  parameter int IN_WIDTH  = bram_pkg::IN_WIDTH_DEF,   // wide word width
  parameter int OUT_WIDTH = bram_pkg::OUT_WIDTH_DEF,  // bank datum width
  parameter int BANKS     = bram_pkg::BANKS_DEF,      // bank count, power of two
  parameter int OUT_DEPTH = bram_pkg::OUT_DEPTH_DEF,  // rows per bank
  localparam int LANES    = bram_pkg::lane_count(IN_WIDTH, OUT_WIDTH),
  localparam int IN_ADDR  = $clog2(BANKS * OUT_DEPTH / LANES)  // wide words in total
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,    // async, active low
  input  logic                  en_i,       // one access per cycle with en_i high
  input  logic [IN_WIDTH/8-1:0] we_i,       // zero means read
  input  logic [IN_ADDR-1:0]    addr_i,     // wide word address
  input  logic [IN_WIDTH-1:0]   wrdata_i,   // write word
  output logic [IN_WIDTH-1:0]   rddata_o    // read word, one cycle after the access
);

  // one port bundle per bank
  bram_bank_if #(
    .OUT_WIDTH (OUT_WIDTH),
    .OUT_DEPTH (OUT_DEPTH)
  ) bank_bus [BANKS] ();

  // address split, enable fan-out and read reassembly
  bram_intrf_translator #(
    .IN_WIDTH  (IN_WIDTH),
    .OUT_WIDTH (OUT_WIDTH),
    .BANKS     (BANKS),
    .OUT_DEPTH (OUT_DEPTH)
  ) u_translator (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .en_i     (en_i),
    .we_i     (we_i),
    .addr_i   (addr_i),
    .wrdata_i (wrdata_i),
    .rddata_o (rddata_o),
    .banks    (bank_bus)
  );

  // the bank memories themselves
  for (genvar i = 0; i < BANKS; i++) begin : g_mem
    bram_bank #(
      .OUT_WIDTH (OUT_WIDTH),
      .OUT_DEPTH (OUT_DEPTH)
    ) u_bank (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .port    (bank_bus[i])
    );
  end

  // capacity is BANKS * OUT_DEPTH data items of OUT_WIDTH bits
  // with the defaults that is 512 wide words of 32 bits
  //
  // latency summary
  //   write   lands on the edge that samples en_i
  //   read    rddata_o valid on the next cycle
  //   idle    rddata_o keeps the last returned word
  //
  // accesses can be issued every cycle

endmodule

//--- banked_bram_tb.sv
`timescale 1ns/1ns

module banked_bram_tb;

  localparam int IN_W   = bram_pkg::IN_WIDTH_DEF;
  localparam int OUT_W  = bram_pkg::OUT_WIDTH_DEF;
  localparam int BANKS  = bram_pkg::BANKS_DEF;
  localparam int DEPTH  = bram_pkg::OUT_DEPTH_DEF;
  localparam int LANES  = bram_pkg::lane_count(IN_W, OUT_W);
  localparam int AW     = $clog2(BANKS * DEPTH / LANES);  // wide word address bits
  localparam int LB     = $clog2(LANES);                  // lane bits below the word address
  localparam int IA_W   = AW + LB;                        // internal data address bits
  localparam int WE_W   = IN_W / 8;
  localparam int LWE    = OUT_W / 8;                      // byte enables per lane
  localparam int WORDS  = 2 ** AW;
  localparam int PERIOD = 4;

  // accesses per test for the watchdog budget
  localparam int N_CLEAR = WORDS;
  localparam int N_FULL  = 2 * WORDS;
  localparam int N_BYTE  = 2 * 32;
  localparam int N_RF    = 2 * 16;
  localparam int N_GATE  = 6 * 8;
  localparam int N_SEP   = 4 * 16;
  localparam int N_RAND  = 2000;
  localparam int N_ALL   = N_CLEAR + N_FULL + N_BYTE + N_RF + N_GATE + N_SEP + N_RAND;
  localparam int TIMEOUT_NS = (N_ALL + 10 + 500) * PERIOD;  // reset plus drain margin

  logic            clk_i;
  logic            rst_n_i;
  logic            en_i;
  logic [WE_W-1:0] we_i;
  logic [AW-1:0]   addr_i;
  logic [IN_W-1:0] wrdata_i;
  logic [IN_W-1:0] rddata_o;

  logic [OUT_W-1:0] ref_mem [2**IA_W];  // model indexed like the internal data address
  logic [IN_W-1:0]  last_exp;           // word rddata_o should hold while idle
  logic [31:0]      lfsr_state;

  logic [IN_W-1:0] exp_q  [$];  // expected words in access order
  bit              chk_q  [$];  // clearing pass is not checked
  string           name_q [$];
  string           test_name;
  int              test_chk0;   // check count when the test started
  int              test_err0;
  int              pending;     // accesses not yet compared
  int              chk_cnt;
  int              err_cnt;

  banked_bram_top #(
    .IN_WIDTH  (IN_W),
    .OUT_WIDTH (OUT_W),
    .BANKS     (BANKS),
    .OUT_DEPTH (DEPTH)
  ) uut (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .en_i     (en_i),
    .we_i     (we_i),
    .addr_i   (addr_i),
    .wrdata_i (wrdata_i),
    .rddata_o (rddata_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(PERIOD / 2) clk_i = ~clk_i;
  end

  // fibonacci lfsr with taps 32 22 2 1 stepped once per bit handed out
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      v = {v[30:0], fb};
    end
    return v;
  endfunction

  // fill word built from the whole address
  function automatic logic [IN_W-1:0] word_pattern(input logic [AW-1:0] a);
    return IN_W'({7'h2b, a, 7'h11, ~a});
  endfunction

  // reference access returns the old lanes at {a, j} and then merges the written bytes
  function automatic logic [IN_W-1:0] ref_access(input logic [AW-1:0] a,
                                                  input logic [WE_W-1:0] we,
                                                  input logic [IN_W-1:0] data);
    logic [IN_W-1:0] old;
    logic [IA_W-1:0] ia;
    for (int j = 0; j < LANES; j++) begin
      ia = {a, LB'(j)};
      old[j*OUT_W +: OUT_W] = ref_mem[ia];  // read first
      for (int b = 0; b < LWE; b++) begin
        if (we[j*LWE + b]) begin
          ref_mem[ia][b*8 +: 8] = data[j*OUT_W + b*8 +: 8];
        end
      end
    end
    return old;
  endfunction

  task automatic check_word(input string name, input logic [IN_W-1:0] exp,
                            input logic [IN_W-1:0] act);
    chk_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("FAILED %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  // one cycle on the port with its expected word queued for the comparer
  task automatic drive(input logic en, input logic [WE_W-1:0] we, input logic [AW-1:0] a,
                       input logic [IN_W-1:0] data, input bit chk);
    logic [IN_W-1:0] exp;
    @(negedge clk_i);
    en_i     = en;
    we_i     = we;
    addr_i   = a;
    wrdata_i = data;
    if (en) begin
      exp      = ref_access(a, we, data);
      last_exp = exp;
    end else begin
      exp = last_exp;  // output holds when idle
    end
    exp_q.push_back(exp);
    chk_q.push_back(chk);
    name_q.push_back(test_name);
    pending++;
  endtask

  task automatic go_idle();
    @(negedge clk_i);
    en_i = 1'b0;
    we_i = '0;
    while (pending != 0) @(negedge clk_i);  // let the comparer catch up
  endtask

  // name the test and remember the counts it starts from
  task automatic start_test(input string name);
    test_name = name;
    test_chk0 = chk_cnt;
    test_err0 = err_cnt;
  endtask

  task automatic report_test();
    $display("test %s: %0d checks, %0d mismatches", test_name,
             chk_cnt - test_chk0, err_cnt - test_err0);
  endtask

  // rddata_o is registered and sampled on the falling edge after the access
  initial begin : compare_proc
    logic [IN_W-1:0] exp;
    bit              chk;
    string           name;
    forever begin
      @(posedge clk_i);
      if (exp_q.size() > 0) begin
        exp  = exp_q.pop_front();
        chk  = chk_q.pop_front();
        name = name_q.pop_front();
        @(negedge clk_i);
        if (chk) check_word(name, exp, rddata_o);
        pending--;
      end
    end
  end

  initial begin
    #(TIMEOUT_NS);
    $display("run timed out after %0d ns with %0d accesses pending", TIMEOUT_NS, pending);
    $display("Errors found");
    $finish;
  end

  initial begin : stim_proc
    logic [AW-1:0]   a;
    logic [AW-1:0]   b;
    logic [IN_W-1:0] d;
    logic [WE_W-1:0] m;
    logic [1:0]      op;
    rst_n_i    = 1'b0;
    en_i       = 1'b0;
    we_i       = '0;
    addr_i     = '0;
    wrdata_i   = '0;
    last_exp   = '0;
    lfsr_state = 32'hc94802fb;
    pending    = 0;
    chk_cnt    = 0;
    err_cnt    = 0;
    start_test("clear");
    for (int i = 0; i < 2**IA_W; i++) ref_mem[i] = '0;
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;

    // banks power up unknown so zero them to match the model
    for (int i = 0; i < WORDS; i++) drive(1'b1, '1, AW'(i), '0, 1'b0);
    go_idle();

    start_test("full_word");
    for (int i = 0; i < WORDS; i++) drive(1'b1, '1, AW'(i), word_pattern(AW'(i)), 1'b1);
    for (int i = 0; i < WORDS; i++) drive(1'b1, '0, AW'(i), '0, 1'b1);
    go_idle();
    report_test();

    start_test("byte_enable");
    for (int k = 0; k < N_BYTE / 2; k++) begin
      a = AW'(rand_bits(AW));
      m = WE_W'(k % (2**WE_W - 1) + 1);  // every nonzero mask in turn
      drive(1'b1, m, a, rand_bits(IN_W), 1'b1);
      drive(1'b1, '0, a, '0, 1'b1);
    end
    go_idle();
    report_test();

    start_test("read_first");
    for (int k = 0; k < N_RF / 2; k++) begin
      a = AW'(rand_bits(AW));
      m = WE_W'(rand_bits(WE_W)) | WE_W'(1);  // at least one byte written
      drive(1'b1, m, a, rand_bits(IN_W), 1'b1);  // old word back
      drive(1'b1, '0, a, '0, 1'b1);              // merged word back
    end
    go_idle();
    report_test();

    start_test("en_gating");
    for (int k = 0; k < N_GATE / 6; k++) begin
      a = AW'(rand_bits(AW));
      drive(1'b1, '1, a, rand_bits(IN_W), 1'b1);
      // idle cycles with live looking write inputs
      for (int n = 0; n < 4; n++) drive(1'b0, '1, a, rand_bits(IN_W), 1'b1);
      drive(1'b1, '0, a, '0, 1'b1);
    end
    go_idle();
    report_test();

    start_test("bank_sep");
    for (int k = 0; k < N_SEP / 4; k++) begin
      a = AW'(rand_bits(AW));
      b = a ^ AW'(1);  // word bit 0 is the upper bank select bit
      drive(1'b1, '1, a, rand_bits(IN_W), 1'b1);
      drive(1'b1, '1, b, rand_bits(IN_W), 1'b1);
      drive(1'b1, '0, a, '0, 1'b1);
      drive(1'b1, '0, b, '0, 1'b1);
    end
    go_idle();
    report_test();

    start_test("random");
    for (int k = 0; k < N_RAND; k++) begin
      op = 2'(rand_bits(2));
      a  = AW'(rand_bits(AW));
      d  = rand_bits(IN_W);
      m  = WE_W'(rand_bits(WE_W));
      case (op)
        2'd0:    drive(1'b1, '0, a, d, 1'b1);  // read
        2'd3:    drive(1'b0, m, a, d, 1'b1);   // idle
        default: drive(1'b1, m, a, d, 1'b1);   // masked write that may be all zero
      endcase
    end
    go_idle();
    report_test();

    $display("done, %0d checks, %0d errors", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

//--- banked_bram.f
bram_pkg.sv
bram_bank_if.sv
bram_bank.sv
bram_intrf_translator.sv
banked_bram_top.sv
banked_bram_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator and run it
# the run passes only when the pass message shows up in the output

verilator --binary --timing --top-module banked_bram_tb \
  -f banked_bram.f -o banked_bram_sim \
  && ./obj_dir/banked_bram_sim | grep "No errors" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

exit 0
